//--- vlog.f
+incdir+.
acq_sample_pkg.sv
acq_result_pkg.sv
acq_corr_if.sv
acq_wipeoff.sv
acq_coh_accum.sv
acq_power.sv
acq_ncoh_peak.sv
acq_top.sv
tb_acq_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_acq_top -f vlog.f -o sim_acq

out=$(./obj_dir/sim_acq)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Result: PASSED"

//--- tb_acq_top.sv
`timescale 1ns/10ps
`include "acq_params.svh"

module tb_acq_top;

    localparam int TRIAL_LEN  = `ACQ_COH_LEN * `ACQ_NCOH_LEN;
    localparam int SEARCH_LEN = TRIAL_LEN * `ACQ_NUM_TRIALS;
    localparam int WAIT_MAX   = 200;
    localparam int STALL_MAX  = `ACQ_IN_CREDITS + 3 * `ACQ_COH_LEN + 4;   // buffers along the pipe

    logic                       core_clk;
    logic                       rst_n;
    logic                       start;
    logic [1:0]                 carrier_step;
    logic                       sample_valid;
    acq_sample_pkg::sample_t    sample;
    logic                       chip;
    logic                       sample_credit;
    logic                       result_valid;
    acq_result_pkg::metric_t    result_metric;
    acq_result_pkg::trial_idx_t result_index;
    logic                       result_credit;

    logic [31:0]                lfsr = 32'd98708;
    int                         src_credits;
    int                         res_seen;
    int                         res_checked;
    int                         errors;
    int                         checks;
    int                         tests;
    bit                         auto_credit;
    bit                         stuck;
    acq_result_pkg::metric_t    got_metric;
    acq_result_pkg::trial_idx_t got_index;
    acq_result_pkg::metric_t    exp_metric_q [$];
    acq_result_pkg::trial_idx_t exp_index_q [$];

    // reference model state
    int                         m_phase;
    int                         m_n;
    int                         m_ci;
    int                         m_cq;
    int                         m_metric;
    int                         m_best;
    int                         m_best_idx;

    acq_top i_acq_top (
        .core_clk      (core_clk),
        .rst_n         (rst_n),
        .start         (start),
        .carrier_step  (carrier_step),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .chip          (chip),
        .sample_credit (sample_credit),
        .result_valid  (result_valid),
        .result_metric (result_metric),
        .result_index  (result_index),
        .result_credit (result_credit)
    );

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic acq_sample_pkg::sample_t rand_sample();
        acq_sample_pkg::sample_t s;
        s.i_sig = next_bit();
        s.i_mag = next_bit();
        s.q_sig = next_bit();
        s.q_mag = next_bit();
        return s;
    endfunction

    task automatic check_metric(input string name, input acq_result_pkg::metric_t got,
                                input acq_result_pkg::metric_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input acq_result_pkg::trial_idx_t got,
                               input acq_result_pkg::trial_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic model_clear();
        m_n        = 0;
        m_ci       = 0;
        m_cq       = 0;
        m_metric   = 0;
        m_best     = -1;      // first trial always taken
        m_best_idx = 0;
    endtask

    task automatic model_step(input acq_sample_pkg::sample_t s, input logic c);
        int wi;
        int wq;
        int ri;
        int rq;
        wi = s.i_mag ? 3 : 1;
        wq = s.q_mag ? 3 : 1;
        if (s.i_sig ^ c) wi = -wi;
        if (s.q_sig ^ c) wq = -wq;
        case (m_phase)
            0: begin ri = wi;  rq = wq;  end
            1: begin ri = wq;  rq = -wi; end
            2: begin ri = -wi; rq = -wq; end
            default: begin ri = -wq; rq = wi; end
        endcase
        m_phase = (m_phase + int'(carrier_step)) % 4;
        m_ci += ri;
        m_cq += rq;
        m_n++;
        if (m_n % `ACQ_COH_LEN == 0) begin
            m_metric += m_ci * m_ci + m_cq * m_cq;
            m_ci = 0;
            m_cq = 0;
        end
        if (m_n % TRIAL_LEN == 0) begin
            if (m_metric > m_best) begin   // ties keep the earlier trial
                m_best     = m_metric;
                m_best_idx = m_n / TRIAL_LEN - 1;
            end
            m_metric = 0;
        end
        if (m_n == SEARCH_LEN) begin
            exp_metric_q.push_back(m_best);
            exp_index_q.push_back(m_best_idx);
            model_clear();
        end
    endtask

    // one clock with outputs sampled and pulses cleared 1 ns after the edge
    task automatic tick();
        @(posedge core_clk);
        #1;
        if (sample_credit) src_credits++;
        if (result_valid) begin
            res_seen++;
            got_metric = result_metric;
            got_index  = result_index;
        end
        sample_valid  = 1'b0;
        start         = 1'b0;
        result_credit = result_valid && auto_credit;
    endtask

    task automatic send(input acq_sample_pkg::sample_t s, input logic c, input int max_wait,
                        output bit sent);
        int waited;
        waited = 0;
        while (src_credits == 0 && waited < max_wait) begin
            tick();
            waited++;
        end
        sent = (src_credits != 0);
        if (sent) begin
            sample_valid = 1'b1;
            sample       = s;
            chip         = c;
            src_credits--;
            model_step(s, c);
            tick();
        end
    endtask

    task automatic push(input acq_sample_pkg::sample_t s, input logic c);
        bit ok;
        if (!stuck) begin
            send(s, c, WAIT_MAX, ok);
            if (!ok) begin
                errors++;
                stuck = 1'b1;
                $display("timeout, no sample credit came back within %0d cycles", WAIT_MAX);
            end
        end
    endtask

    task automatic push_random();
        logic c;
        acq_sample_pkg::sample_t s;
        c = next_bit();
        s = rand_sample();
        push(s, c);
    endtask

    // peak_trial < 0 gives random data everywhere
    task automatic send_search(input int peak_trial);
        logic c;
        for (int n = 0; n < SEARCH_LEN; n++) begin
            if (n / TRIAL_LEN == peak_trial) begin
                c = next_bit();
                push('{i_sig: c, i_mag: 1'b1, q_sig: c, q_mag: 1'b1}, c);
            end else begin
                push_random();
            end
        end
    endtask

    task automatic expect_result();
        int waited;
        waited = 0;
        if (!stuck) begin
            while (res_seen == res_checked && waited < WAIT_MAX) begin
                tick();
                waited++;
            end
            if (res_seen == res_checked) begin
                errors++;
                stuck = 1'b1;
                $display("timeout, no result_valid within %0d cycles", WAIT_MAX);
            end else if (exp_metric_q.size() == 0) begin
                errors++;
                res_checked = res_seen;
                $display("result_valid came without a finished search");
            end else begin
                res_checked++;
                check_metric("result_metric", got_metric, exp_metric_q.pop_front());
                check_index("result_index", got_index, exp_index_q.pop_front());
            end
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (20) begin
            tick();
            check_bit("result_valid", result_valid, 1'b0);
            check_bit("sample_credit", sample_credit, 1'b0);
        end
        report_test("idle after reset", e0);
    endtask

    task automatic peak_in_trial();
        int e0;
        e0 = errors;
        carrier_step = 2'd0;
        send_search(9);
        expect_result();
        check_index("result_index", got_index, 9);
        report_test("peak in trial 9", e0);
    endtask

    task automatic rotated_search();
        int e0;
        e0 = errors;
        carrier_step = 2'd1;
        send_search(-1);
        expect_result();
        report_test("rotated search", e0);
    endtask

    task automatic held_result();
        int e0;
        int seen0;
        int sent_c;
        bit ok;
        logic c;
        acq_sample_pkg::sample_t s;
        acq_result_pkg::metric_t held_m;
        acq_result_pkg::trial_idx_t held_i;
        e0 = errors;
        auto_credit = 1'b0;
        send_search(-1);          // uses the one credit the DUT holds
        held_m = exp_metric_q[$];
        held_i = exp_index_q[$];
        expect_result();
        seen0  = res_seen;
        send_search(-1);          // parks inside the DUT
        sent_c = 0;
        ok     = 1'b1;
        while (ok && !stuck && sent_c < SEARCH_LEN) begin
            c = next_bit();
            s = rand_sample();
            send(s, c, 50, ok);
            if (ok) sent_c++;
        end
        if (sent_c >= STALL_MAX) begin
            errors++;
            $display("sample credits kept coming under back-pressure, %0d samples", sent_c);
        end
        check_bit("result_valid while held", res_seen != seen0, 1'b0);
        check_metric("held result_metric", result_metric, held_m);
        check_index("held result_index", result_index, held_i);
        result_credit = 1'b1;
        auto_credit   = 1'b1;
        tick();
        expect_result();
        repeat (SEARCH_LEN - sent_c) push_random();
        expect_result();
        report_test("held result", e0);
    endtask

    task automatic restart_mid_search();
        int e0;
        e0 = errors;
        repeat (3 * TRIAL_LEN + 5) push_random();
        start       = 1'b1;
        src_credits = `ACQ_IN_CREDITS;   // FIFO emptied by start
        m_phase     = 0;
        model_clear();
        tick();
        send_search(-1);
        expect_result();
        report_test("restart mid search", e0);
    endtask

    task automatic equal_trials();
        int e0;
        acq_sample_pkg::sample_t s_arr [TRIAL_LEN];
        logic c_arr [TRIAL_LEN];
        e0 = errors;
        for (int n = 0; n < TRIAL_LEN; n++) begin
            c_arr[n] = next_bit();
            s_arr[n] = rand_sample();
        end
        repeat (`ACQ_NUM_TRIALS) begin
            for (int n = 0; n < TRIAL_LEN; n++) push(s_arr[n], c_arr[n]);
        end
        expect_result();
        check_index("result_index", got_index, 0);
        report_test("equal trials", e0);
    endtask

    initial begin
        rst_n         = 1'b0;
        start         = 1'b0;
        carrier_step  = 2'd0;
        sample_valid  = 1'b0;
        sample        = '0;
        chip          = 1'b0;
        result_credit = 1'b0;
        src_credits   = `ACQ_IN_CREDITS;
        res_seen      = 0;
        res_checked   = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        auto_credit   = 1'b1;
        stuck         = 1'b0;
        m_phase       = 0;
        model_clear();
        repeat (3) @(posedge core_clk);
        #1;
        rst_n = 1'b1;
        idle_after_reset();
        peak_in_trial();
        rotated_search();
        held_result();
        restart_mid_search();
        equal_trials();
        check_bit("extra result_valid", res_seen != res_checked, 1'b0);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- acq_top.sv
`timescale 1ns/10ps

module acq_top (
    input  logic                       core_clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [1:0]                 carrier_step,   // static during a search
    input  logic                       sample_valid,
    input  acq_sample_pkg::sample_t    sample,
    input  logic                       chip,
    output logic                       sample_credit,
    output logic                       result_valid,
    output acq_result_pkg::metric_t    result_metric,
    output acq_result_pkg::trial_idx_t result_index,
    input  logic                       result_credit
);

    acq_corr_if wipe_coh ();
    acq_corr_if coh_pwr ();

    logic                   power_valid;
    acq_result_pkg::power_t power;
    logic                   power_credit;

    acq_wipeoff i_acq_wipeoff (
        .core_clk      (core_clk),
        .rst_n         (rst_n),
        .start         (start),
        .carrier_step  (carrier_step),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .chip          (chip),
        .sample_credit (sample_credit),
        .out           (wipe_coh.sender)
    );

    acq_coh_accum i_acq_coh_accum (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .start    (start),
        .in       (wipe_coh.receiver),
        .out      (coh_pwr.sender)
    );

    acq_power i_acq_power (
        .core_clk     (core_clk),
        .rst_n        (rst_n),
        .start        (start),
        .in           (coh_pwr.receiver),
        .power_valid  (power_valid),
        .power        (power),
        .power_credit (power_credit)
    );

    acq_ncoh_peak i_acq_ncoh_peak (
        .core_clk      (core_clk),
        .rst_n         (rst_n),
        .start         (start),
        .power_valid   (power_valid),
        .power         (power),
        .power_credit  (power_credit),
        .result_valid  (result_valid),
        .result_metric (result_metric),
        .result_index  (result_index),
        .result_credit (result_credit)
    );

endmodule

//--- acq_ncoh_peak.sv
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_ncoh_peak (
    input  logic                       core_clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       power_valid,
    input  acq_result_pkg::power_t     power,
    output logic                       power_credit,
    output logic                       result_valid,    // one pulse per search
    output acq_result_pkg::metric_t    result_metric,   // held until the next result
    output acq_result_pkg::trial_idx_t result_index,
    input  logic                       result_credit
);

    localparam int NCOH_W = $clog2(`ACQ_NCOH_LEN);

    logic                       buf_valid;
    acq_result_pkg::power_t     buf_power;
    acq_result_pkg::metric_t    acc;
    acq_result_pkg::metric_t    sum;
    acq_result_pkg::metric_t    max_metric;
    acq_result_pkg::metric_t    fin_metric;
    acq_result_pkg::metric_t    metric_r;
    acq_result_pkg::trial_idx_t trial;
    acq_result_pkg::trial_idx_t max_idx;
    acq_result_pkg::trial_idx_t fin_idx;
    acq_result_pkg::trial_idx_t index_r;
    logic [NCOH_W-1:0]          ncoh_cnt;
    logic                       consume;
    logic                       trial_end;
    logic                       last;
    logic                       better;
    logic                       emit;
    logic                       pending;      // finished search waiting for the result credit
    logic                       res_credit;
    logic                       credit_r;
    logic                       valid_r;

    assign consume   = buf_valid && !pending;
    assign sum       = acc + acq_result_pkg::metric_t'(buf_power);
    assign trial_end = (ncoh_cnt == NCOH_W'(`ACQ_NCOH_LEN-1));
    assign better    = (sum > max_metric);          // strict, earliest trial wins ties
    assign fin_metric = better ? sum : max_metric;
    assign fin_idx    = better ? trial : max_idx;
    assign last = consume && trial_end
               && (trial == acq_result_pkg::trial_idx_t'(`ACQ_NUM_TRIALS-1));
    assign emit = res_credit && (last || pending);

    always_ff @(posedge core_clk) begin
        if (!rst_n || start) begin
            buf_valid  <= 1'b0;
            acc        <= '0;
            ncoh_cnt   <= '0;
            trial      <= '0;
            max_metric <= '0;
            max_idx    <= '0;
            pending    <= 1'b0;
            credit_r   <= 1'b0;
            valid_r    <= 1'b0;
            // result credit belongs to the consumer, start keeps it
            res_credit <= !rst_n ? 1'b1 : (res_credit | result_credit);
        end else begin
            if (power_valid) begin
                buf_valid <= 1'b1;
            end else if (consume) begin
                buf_valid <= 1'b0;
            end
            if (consume) begin
                if (trial_end) begin
                    acc        <= '0;
                    ncoh_cnt   <= '0;
                    trial      <= last ? '0 : trial + 1'b1;
                    max_metric <= fin_metric;
                    max_idx    <= fin_idx;
                end else begin
                    acc      <= sum;
                    ncoh_cnt <= ncoh_cnt + 1'b1;
                end
            end
            if (emit) begin
                max_metric <= '0;   // next search starts clean
                max_idx    <= '0;
                pending    <= 1'b0;
            end else if (last) begin
                pending <= 1'b1;
            end
            res_credit <= (res_credit & ~emit) | result_credit;
            credit_r   <= consume;
            valid_r    <= emit;
        end
    end

    always_ff @(posedge core_clk) begin
        if (power_valid) begin
            buf_power <= power;
        end
        if (emit) begin
            metric_r <= pending ? max_metric : fin_metric;
            index_r  <= pending ? max_idx : fin_idx;
        end
    end

    assign power_credit  = credit_r;
    assign result_valid  = valid_r;
    assign result_metric = metric_r;
    assign result_index  = index_r;

endmodule

//--- acq_power.sv
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_power (
    input  logic                   core_clk,
    input  logic                   rst_n,
    input  logic                   start,
    acq_corr_if.receiver           in,
    output logic                   power_valid,
    output acq_result_pkg::power_t power,
    input  logic                   power_credit
);

    logic                          buf_valid;
    acq_sample_pkg::corr_t         buf_i;
    acq_sample_pkg::corr_t         buf_q;
    logic signed [2*`ACQ_CORR_W-1:0] sq_i;
    logic signed [2*`ACQ_CORR_W-1:0] sq_q;
    logic                          consume;
    logic                          credits;
    logic                          credit_r;
    logic                          valid_r;
    acq_result_pkg::power_t        power_r;

    assign sq_i    = buf_i * buf_i;   // full width, never negative
    assign sq_q    = buf_q * buf_q;
    assign consume = buf_valid && credits;

    always_ff @(posedge core_clk) begin
        if (!rst_n || start) begin
            buf_valid <= 1'b0;
            credits   <= 1'b1;
            credit_r  <= 1'b0;
            valid_r   <= 1'b0;
        end else begin
            if (in.valid) begin
                buf_valid <= 1'b1;
            end else if (consume) begin
                buf_valid <= 1'b0;
            end
            credits  <= (credits & ~consume) | power_credit;
            credit_r <= consume;
            valid_r  <= consume;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in.valid) begin
            buf_i <= in.i;
            buf_q <= in.q;
        end
        if (consume) begin
            power_r <= acq_result_pkg::power_t'(sq_i) + acq_result_pkg::power_t'(sq_q);
        end
    end

    assign in.credit   = credit_r;
    assign power_valid = valid_r;
    assign power       = power_r;

endmodule

//--- acq_coh_accum.sv
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_coh_accum (
    input  logic         core_clk,
    input  logic         rst_n,
    input  logic         start,
    acq_corr_if.receiver in,
    acq_corr_if.sender   out
);

    localparam int CNT_W = $clog2(`ACQ_COH_LEN);

    logic                  buf_valid;
    acq_sample_pkg::corr_t buf_i;
    acq_sample_pkg::corr_t buf_q;
    acq_sample_pkg::corr_t i_sum;
    acq_sample_pkg::corr_t q_sum;
    acq_sample_pkg::corr_t i_next;
    acq_sample_pkg::corr_t q_next;
    acq_sample_pkg::corr_t i_out;
    acq_sample_pkg::corr_t q_out;
    logic [CNT_W-1:0]      cnt;
    logic                  closing;
    logic                  consume;
    logic                  send;
    logic                  credits;
    logic                  credit_r;
    logic                  valid_r;

    assign i_next  = i_sum + buf_i;
    assign q_next  = q_sum + buf_q;
    assign closing = (cnt == CNT_W'(`ACQ_COH_LEN-1));
    assign consume = buf_valid && (!closing || credits);  // closing beat waits for a credit
    assign send    = consume && closing;

    always_ff @(posedge core_clk) begin
        if (!rst_n || start) begin
            buf_valid <= 1'b0;
            i_sum     <= '0;
            q_sum     <= '0;
            cnt       <= '0;
            credits   <= 1'b1;
            credit_r  <= 1'b0;
            valid_r   <= 1'b0;
        end else begin
            if (in.valid) begin
                buf_valid <= 1'b1;
            end else if (consume) begin
                buf_valid <= 1'b0;
            end
            if (consume) begin
                i_sum <= closing ? '0 : i_next;
                q_sum <= closing ? '0 : q_next;
                cnt   <= closing ? '0 : cnt + 1'b1;
            end
            credits  <= (credits & ~send) | out.credit;
            credit_r <= consume;
            valid_r  <= send;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in.valid) begin
            buf_i <= in.i;
            buf_q <= in.q;
        end
        if (send) begin
            i_out <= i_next;
            q_out <= q_next;
        end
    end

    assign in.credit = credit_r;
    assign out.valid = valid_r;
    assign out.i     = i_out;
    assign out.q     = q_out;

endmodule

//--- acq_wipeoff.sv
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_wipeoff (
    input  logic                      core_clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [1:0]                carrier_step,
    input  logic                      sample_valid,
    input  acq_sample_pkg::sample_t   sample,
    input  logic                      chip,
    output logic                      sample_credit,   // source reloads its credits on start
    acq_corr_if.sender                out
);

    localparam int DEPTH = `ACQ_IN_CREDITS;
    localparam int AW    = $clog2(DEPTH);
    localparam int SW    = $bits(acq_sample_pkg::sample_t);

    logic [SW:0]             fifo_mem [0:DEPTH-1];   // {chip, sample}
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [AW:0]             count;
    logic [SW:0]             head;
    acq_sample_pkg::sample_t head_s;
    logic                    pop;
    logic [1:0]              phase;
    logic                    credits;
    logic                    credit_r;
    logic                    valid_r;
    acq_sample_pkg::corr_t   wi;
    acq_sample_pkg::corr_t   wq;
    acq_sample_pkg::corr_t   rot_i;
    acq_sample_pkg::corr_t   rot_q;
    acq_sample_pkg::corr_t   out_i;
    acq_sample_pkg::corr_t   out_q;

    // +-1 / +-3, chip=1 flips the sign
    function automatic acq_sample_pkg::corr_t level(input logic sig, input logic mag,
                                                    input logic c);
        acq_sample_pkg::corr_t v;
        v = mag ? 8'sd3 : 8'sd1;
        if (sig ^ c) begin
            v = -v;
        end
        return v;
    endfunction

    assign head   = fifo_mem[rd_ptr];
    assign head_s = acq_sample_pkg::sample_t'(head[SW-1:0]);
    assign pop    = (count != '0) && credits;

    assign wi = level(head_s.i_sig, head_s.i_mag, head[SW]);
    assign wq = level(head_s.q_sig, head_s.q_mag, head[SW]);

    // quarter-cycle carrier rotation
    always_comb begin
        case (phase)
            2'd0: begin rot_i = wi;  rot_q = wq;  end
            2'd1: begin rot_i = wq;  rot_q = -wi; end
            2'd2: begin rot_i = -wi; rot_q = -wq; end
            default: begin rot_i = -wq; rot_q = wi; end
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n || start) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            phase    <= 2'd0;
            credits  <= 1'b1;
            credit_r <= 1'b0;
            valid_r  <= 1'b0;
        end else begin
            if (sample_valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                phase  <= phase + carrier_step;
            end
            count    <= count + (AW+1)'(sample_valid) - (AW+1)'(pop);
            credits  <= (credits & ~pop) | out.credit;
            credit_r <= pop;
            valid_r  <= pop;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sample_valid) begin
            fifo_mem[wr_ptr] <= {chip, sample};
        end
        if (pop) begin
            out_i <= rot_i;
            out_q <= rot_q;
        end
    end

    assign sample_credit = credit_r;
    assign out.valid     = valid_r;
    assign out.i         = out_i;
    assign out.q         = out_q;

endmodule

//--- acq_corr_if.sv
`timescale 1ns/10ps

// one correlation beat per valid, credit flows back from the receiver
interface acq_corr_if;

    logic                  valid;
    acq_sample_pkg::corr_t i;
    acq_sample_pkg::corr_t q;
    logic                  credit;     // one pulse per beat taken out of the receiver buffer

    modport sender (
        output valid,
        output i,
        output q,
        input  credit
    );

    modport receiver (
        input  valid,
        input  i,
        input  q,
        output credit
    );

endinterface

//--- acq_result_pkg.sv
`include "acq_params.svh"

package acq_result_pkg;

    typedef logic [2*`ACQ_CORR_W-1:0] power_t;       // I^2 + Q^2

    typedef logic [`ACQ_METRIC_W-1:0] metric_t;      // sum of powers over a trial

    typedef logic [$clog2(`ACQ_NUM_TRIALS)-1:0] trial_idx_t;

endpackage

//--- acq_sample_pkg.sv
`include "acq_params.svh"

package acq_sample_pkg;

    // 2-bit sign/magnitude per component, sig=1 negative, mag=1 means 3
    typedef struct packed {
        logic i_sig;
        logic i_mag;
        logic q_sig;
        logic q_mag;
    } sample_t;

    // wiped-off products and coherent sums
    typedef logic signed [`ACQ_CORR_W-1:0] corr_t;

endpackage

//--- acq_params.svh
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// samples summed in one coherent interval
`define ACQ_COH_LEN 8

// coherent sums per trial
`define ACQ_NCOH_LEN 4

// trials in one search
`define ACQ_NUM_TRIALS 16

// depth of the sample FIFO in front of the wipe-off
`define ACQ_IN_CREDITS 4

// signed width of I and Q correlation values
`define ACQ_CORR_W 8

// width of the non-coherent trial metric
`define ACQ_METRIC_W 24

`endif
